// ==== include/lg_regmap.svh ====
/*
  Register map of the logic pattern generator, as byte offsets on the strobe bus.
  Included by the configuration package and by the testbench bus tasks.
*/
`ifndef LG_REGMAP_SVH
`define LG_REGMAP_SVH

`define LG_REG_CTL  'h00  // control write, status read
`define LG_REG_TRG  'h08  // external trigger mask
`define LG_REG_MOD  'h10  // mode {inf, ben}
`define LG_REG_SIZ  'h14  // table size, 8.8 fixed point
`define LG_REG_OFF  'h18  // start offset, 8.8
`define LG_REG_STE  'h1c  // step, 8.8
`define LG_REG_BDL  'h24  // burst data length
`define LG_REG_BPL  'h28  // burst period length
`define LG_REG_BPN  'h2c  // burst period number
`define LG_REG_SBL  'h30  // live period counter
`define LG_REG_SBN  'h34  // live period number counter
`define LG_REG_OEN  'h40  // output enable
`define LG_REG_MSK  'h44  // data mask
`define LG_REG_VAL  'h48  // fixed value
`define LG_REG_POL  'h4c  // polarity
// table window, bit 7 set, entry index in address bits 15:8
`define LG_TBL_BASE 'h80
`define LG_TBL_STEP 'h100

`endif

// ==== rtl/lg_cfg_pkg.sv ====
/*
  Widths, register offsets and configuration types of the pattern generator.
  Imported by the register block, the sequencer, the output stage and the top.
*/
package lg_cfg_pkg;

`include "lg_regmap.svh"

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  localparam int dat_w     = 8;            // sample width
  localparam int tbl_aw    = 8;            // 256 entry table
  localparam int ptr_fw    = 8;            // pointer fraction bits
  localparam int ptr_w     = tbl_aw + ptr_fw;
  localparam int bpl_w     = 16;
  localparam int bpn_w     = 16;
  localparam int reg_aw    = 7;            // register offset field
  localparam int bus_aw    = 16;           // full bus address
  localparam int reg_dw    = 32;
  localparam int ext_trg_n = 4;
  localparam int tbl_sel   = 7;            // address bit that picks the table
  localparam int tbl_lsb   = 8;            // table index starts here

  //////////////////////////////////////////////////
  // vector types
  //////////////////////////////////////////////////

  typedef logic [dat_w-1:0]     dat_t;
  typedef logic [tbl_aw-1:0]    tbl_adr_t;
  typedef logic [tbl_aw:0]      bdl_t;     // up to a full table
  typedef logic [ptr_w-1:0]     ptr_t;     // 8.8 fixed point
  typedef logic [bpl_w-1:0]     bpl_t;
  typedef logic [bpn_w-1:0]     bpn_t;
  typedef logic [bus_aw-1:0]    reg_adr_t;
  typedef logic [reg_aw-1:0]    reg_off_t;
  typedef logic [reg_dw-1:0]    reg_dat_t;
  typedef logic [ext_trg_n-1:0] trg_t;

  // register offsets, low address bits
  localparam reg_off_t reg_ctl = `LG_REG_CTL;
  localparam reg_off_t reg_trg = `LG_REG_TRG;
  localparam reg_off_t reg_mod = `LG_REG_MOD;
  localparam reg_off_t reg_siz = `LG_REG_SIZ;
  localparam reg_off_t reg_off = `LG_REG_OFF;
  localparam reg_off_t reg_ste = `LG_REG_STE;
  localparam reg_off_t reg_bdl = `LG_REG_BDL;
  localparam reg_off_t reg_bpl = `LG_REG_BPL;
  localparam reg_off_t reg_bpn = `LG_REG_BPN;
  localparam reg_off_t reg_sbl = `LG_REG_SBL;
  localparam reg_off_t reg_sbn = `LG_REG_SBN;
  localparam reg_off_t reg_oen = `LG_REG_OEN;
  localparam reg_off_t reg_msk = `LG_REG_MSK;
  localparam reg_off_t reg_val = `LG_REG_VAL;
  localparam reg_off_t reg_pol = `LG_REG_POL;

  typedef struct packed {
    logic ben;      // burst enable
    logic inf;      // endless burst
    ptr_t siz;      // wrap point
    ptr_t off;      // phase
    ptr_t ste;      // rate
    bdl_t bdl;      // samples per period
    bpl_t bpl;      // steps per period
    bpn_t bpn;      // periods per burst
    dat_t oen;
    dat_t msk;
    dat_t val;
    dat_t pol;
    trg_t trg_msk;
  } lg_cfg_t;

  typedef struct packed {
    bpl_t bpl;      // live period counter
    bpn_t bpn;      // live period number
    logic run;
  } lg_sts_t;

endpackage

// ==== rtl/lg_evn_pkg.sv ====
/*
  Event and state types of the pattern generator sequencer.
  Software strobes go in, period and last pulses come out.
*/
package lg_evn_pkg;

  //////////////////////////////////////////////////
  // events
  //////////////////////////////////////////////////

  // one cycle strobes from the control register
  typedef struct packed {
    logic str;      // start, idle to armed
    logic stp;      // stop, back to idle
    logic swt;      // software trigger
  } lg_evn_t;

  // pulses from the sequencer
  typedef struct packed {
    logic per;      // first sample of a period
    logic lst;      // finite burst finished
  } lg_tro_t;

  //////////////////////////////////////////////////
  // sequencer states
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    idle,           // waits for start
    armed,          // waits for a trigger
    run_data,       // issues samples
    run_gap         // rest of the period, no samples
  } seq_state_t;

endpackage

// ==== rtl/lg_regs.sv ====
/*
  Register block of the pattern generator on the strobe bus.
  Holds the configuration, turns control writes into strobes, masks the
  external triggers, forwards table writes and raises the interrupt.
*/
`timescale 1ns/1ps

module lg_regs
  import lg_cfg_pkg::*, lg_evn_pkg::*;
(
  input  logic     bus,
  input  logic     rst_n,
  input  logic     reg_wen,
  input  logic     reg_ren,
  input  reg_adr_t reg_addr,
  input  reg_dat_t reg_wdata,
  output reg_dat_t reg_rdata,
  output logic     reg_ack,
  input  trg_t     ext_trg,
  output lg_cfg_t  cfg,
  output lg_evn_t  evn,
  output logic     trg_hit,
  input  lg_sts_t  sts,
  input  lg_tro_t  tro,
  output logic     tbl_we,
  output tbl_adr_t tbl_adr,
  output dat_t     tbl_dat,
  output logic     irq
);

  reg_off_t roff;      // offset inside the register window
  logic     reg_wr;    // write to a register
  logic     tbl_wr;    // write to the table window
  trg_t     trg_q;     // trigger input stage
  reg_dat_t rd_mux;

  assign roff   = reg_addr[reg_aw-1:0];
  assign reg_wr = reg_wen & ~reg_addr[tbl_sel];
  assign tbl_wr = reg_wen &  reg_addr[tbl_sel];

  //////////////////////////////////////////////////
  // bus handshake and events
  //////////////////////////////////////////////////

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      reg_ack <= 1'b0;
      evn     <= '0;
      tbl_we  <= 1'b0;
      trg_q   <= '0;
      trg_hit <= 1'b0;
      irq     <= 1'b0;
    end else begin
      reg_ack <= reg_wen | reg_ren;  // one cycle after any access
      evn.str <= reg_wr && roff == reg_ctl && reg_wdata[0];
      evn.stp <= reg_wr && roff == reg_ctl && reg_wdata[1];
      evn.swt <= reg_wr && roff == reg_ctl && reg_wdata[2];
      tbl_we  <= tbl_wr;
      trg_q   <= ext_trg;
      trg_hit <= |(trg_q & cfg.trg_msk);  // second stage
      irq     <= tro.lst;
    end
  end

  // table write data, qualified by tbl_we
  always_ff @(posedge bus) begin
    tbl_adr <= reg_addr[tbl_lsb+tbl_aw-1:tbl_lsb];
    tbl_dat <= reg_wdata[dat_w-1:0];
  end

  //////////////////////////////////////////////////
  // configuration registers
  //////////////////////////////////////////////////

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      cfg <= '0;
    end else if (reg_wr) begin
      case (roff)
        reg_trg: cfg.trg_msk <= reg_wdata[ext_trg_n-1:0];
        reg_mod: begin
          cfg.ben <= reg_wdata[0];
          cfg.inf <= reg_wdata[1];
        end
        reg_siz: cfg.siz <= reg_wdata[ptr_w-1:0];
        reg_off: cfg.off <= reg_wdata[ptr_w-1:0];
        reg_ste: cfg.ste <= reg_wdata[ptr_w-1:0];
        reg_bdl: cfg.bdl <= reg_wdata[tbl_aw:0];
        reg_bpl: cfg.bpl <= reg_wdata[bpl_w-1:0];
        reg_bpn: cfg.bpn <= reg_wdata[bpn_w-1:0];
        reg_oen: cfg.oen <= reg_wdata[dat_w-1:0];
        reg_msk: cfg.msk <= reg_wdata[dat_w-1:0];
        reg_val: cfg.val <= reg_wdata[dat_w-1:0];
        reg_pol: cfg.pol <= reg_wdata[dat_w-1:0];
        default: ;  // status and holes are read only
      endcase
    end
  end

  //////////////////////////////////////////////////
  // readback
  //////////////////////////////////////////////////

  always_comb begin
    rd_mux = '0;  // holes and table read as zero
    if (!reg_addr[tbl_sel]) begin
      case (roff)
        reg_ctl: rd_mux = reg_dat_t'({tro.lst, tro.per, sts.run});
        reg_trg: rd_mux = reg_dat_t'(cfg.trg_msk);
        reg_mod: rd_mux = reg_dat_t'({cfg.inf, cfg.ben});
        reg_siz: rd_mux = reg_dat_t'(cfg.siz);
        reg_off: rd_mux = reg_dat_t'(cfg.off);
        reg_ste: rd_mux = reg_dat_t'(cfg.ste);
        reg_bdl: rd_mux = reg_dat_t'(cfg.bdl);
        reg_bpl: rd_mux = reg_dat_t'(cfg.bpl);
        reg_bpn: rd_mux = reg_dat_t'(cfg.bpn);
        reg_sbl: rd_mux = reg_dat_t'(sts.bpl);
        reg_sbn: rd_mux = reg_dat_t'(sts.bpn);
        reg_oen: rd_mux = reg_dat_t'(cfg.oen);
        reg_msk: rd_mux = reg_dat_t'(cfg.msk);
        reg_val: rd_mux = reg_dat_t'(cfg.val);
        reg_pol: rd_mux = reg_dat_t'(cfg.pol);
        default: rd_mux = '0;
      endcase
    end
  end

  always_ff @(posedge bus) begin
    reg_rdata <= rd_mux;  // lines up with reg_ack
  end

endmodule

// ==== rtl/lg_seq.sv ====
/*
  Sequencer of the pattern generator with its 256x8 waveform table.
  Walks the table with an 8.8 pointer, continuously or in bursts of periods,
  and feeds samples into a valid/ready stream that stalls on back-pressure.
*/
`timescale 1ns/1ps

module lg_seq
  import lg_cfg_pkg::*, lg_evn_pkg::*;
(
  input  logic     bus,
  input  logic     rst_n,
  input  lg_cfg_t  cfg,
  input  lg_evn_t  evn,
  input  logic     trg_hit,
  input  logic     tbl_we,
  input  tbl_adr_t tbl_adr,
  input  dat_t     tbl_dat,
  output logic     raw_vld,
  output dat_t     raw_dat,
  input  logic     raw_rdy,
  output lg_sts_t  sts,
  output lg_tro_t  tro
);

  dat_t       mem [2**tbl_aw];  // waveform table
  seq_state_t state;
  ptr_t       ptr;              // next sample position
  ptr_t       src;              // position read this cycle
  bdl_t       dat_cnt;          // samples in this period
  bdl_t       dat_nxt;
  bpl_t       bpl_cnt;          // steps in this period
  bpn_t       bpn_cnt;          // periods started
  logic       step;             // output slot free
  logic       issue;            // put a sample out
  logic       restart;          // new period at the offset
  logic       finish;           // last period done

  // pointer advance with wrap at the table size
  function automatic ptr_t ptr_adv(ptr_t p, ptr_t ste, ptr_t siz);
    logic [ptr_w:0] sum;
    sum = {1'b0, p} + {1'b0, ste};
    if (sum >= {1'b0, siz}) begin
      sum = sum - {1'b0, siz};
    end
    return sum[ptr_w-1:0];
  endfunction

  //////////////////////////////////////////////////
  // table
  //////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (tbl_we) begin
      mem[tbl_adr] <= tbl_dat;
    end
  end

  always_ff @(posedge bus) begin
    if (issue) begin
      raw_dat <= mem[src[ptr_w-1:ptr_fw]];  // integer part only
    end
  end

  //////////////////////////////////////////////////
  // run control
  //////////////////////////////////////////////////

  assign step = ~raw_vld | raw_rdy;

  always_comb begin
    restart = 1'b0;
    finish  = 1'b0;
    issue   = 1'b0;
    case (state)
      armed:    restart = evn.swt | trg_hit;
      run_data: issue   = step;
      run_gap: begin
        if (step && bpl_cnt >= cfg.bpl) begin  // period used up
          if (!cfg.inf && bpn_cnt >= cfg.bpn) begin
            finish = 1'b1;
          end else begin
            restart = 1'b1;
          end
        end
      end
      default: ;
    endcase
    if (restart) begin
      issue = 1'b1;
    end
    src     = restart ? cfg.off : ptr;
    dat_nxt = restart ? bdl_t'(1) : dat_cnt + 1'b1;
  end

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      state   <= idle;
      raw_vld <= 1'b0;
      ptr     <= '0;
      dat_cnt <= '0;
      bpl_cnt <= '0;
      bpn_cnt <= '0;
      tro     <= '0;
    end else begin
      tro <= '0;  // pulses only
      if (evn.stp) begin
        state   <= idle;  // abort from anywhere
        raw_vld <= 1'b0;
      end else if (state == idle) begin
        if (evn.str) begin
          state <= armed;
        end
      end else begin
        if (issue) begin
          raw_vld <= 1'b1;
          ptr     <= ptr_adv(src, cfg.ste, cfg.siz);
          dat_cnt <= dat_nxt;
          // burst mode leaves for the gap after the data length
          state   <= (cfg.ben && dat_nxt >= cfg.bdl) ? run_gap : run_data;
        end else if (step) begin
          raw_vld <= 1'b0;  // last sample gone, nothing new
        end
        if (restart) begin
          tro.per <= 1'b1;  // with the first sample
          bpl_cnt <= bpl_t'(1);
          bpn_cnt <= (state == armed) ? bpn_t'(1) : bpn_cnt + 1'b1;
        end else if (step && state != armed) begin
          bpl_cnt <= bpl_cnt + 1'b1;
        end
        if (finish) begin
          tro.lst <= 1'b1;
          state   <= idle;
        end
      end
    end
  end

  assign sts.bpl = bpl_cnt;
  assign sts.bpn = bpn_cnt;
  assign sts.run = state != idle;

endmodule

// ==== rtl/lg_out.sv ====
/*
  Output stage of the pattern generator, a one entry stream register.
  Mixes table data with the fixed value under the mask, applies the polarity
  and shows the output enable while a sample is held.
*/
`timescale 1ns/1ps

module lg_out
  import lg_cfg_pkg::*;
(
  input  logic    bus,
  input  logic    rst_n,
  input  lg_cfg_t cfg,
  input  logic    raw_vld,
  input  dat_t    raw_dat,
  output logic    raw_rdy,
  output logic    out_vld,
  output dat_t    out_dat,
  output dat_t    out_oe,
  input  logic    out_rdy
);

  dat_t mix;  // combined sample

  // empty or draining this cycle
  assign raw_rdy = ~out_vld | out_rdy;

  assign mix = cfg.pol ^ ((cfg.msk & raw_dat) | (~cfg.msk & cfg.val));

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      out_vld <= 1'b0;
    end else if (raw_rdy) begin
      out_vld <= raw_vld;
    end
  end

  always_ff @(posedge bus) begin
    if (raw_rdy && raw_vld) begin
      out_dat <= mix;  // held while stalled
    end
  end

  assign out_oe = out_vld ? cfg.oen : '0;  // tristate when idle

endmodule

// ==== rtl/lg_top.sv ====
/*
  Top level of the bus-programmed logic pattern generator.
  Register block, sequencer with table and output stage, wired together.
*/
`timescale 1ns/1ps

module lg_top
  import lg_cfg_pkg::*, lg_evn_pkg::*;
(
  input  logic     bus,
  input  logic     rst_n,
  input  logic     reg_wen,
  input  logic     reg_ren,
  input  reg_adr_t reg_addr,
  input  reg_dat_t reg_wdata,
  output reg_dat_t reg_rdata,
  output logic     reg_ack,
  input  trg_t     ext_trg,
  output logic     out_vld,
  output dat_t     out_dat,
  output dat_t     out_oe,
  input  logic     out_rdy,
  output logic     irq
);

  lg_cfg_t  cfg;
  lg_evn_t  evn;
  logic     trg_hit;
  lg_sts_t  sts;
  lg_tro_t  tro;
  logic     tbl_we;
  tbl_adr_t tbl_adr;
  dat_t     tbl_dat;
  logic     raw_vld;   // sequencer stream
  dat_t     raw_dat;
  logic     raw_rdy;

  lg_regs u_regs (
    .bus       (bus),
    .rst_n     (rst_n),
    .reg_wen   (reg_wen),
    .reg_ren   (reg_ren),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .reg_ack   (reg_ack),
    .ext_trg   (ext_trg),
    .cfg       (cfg),
    .evn       (evn),
    .trg_hit   (trg_hit),
    .sts       (sts),
    .tro       (tro),
    .tbl_we    (tbl_we),
    .tbl_adr   (tbl_adr),
    .tbl_dat   (tbl_dat),
    .irq       (irq)
  );

  lg_seq u_seq (
    .bus     (bus),
    .rst_n   (rst_n),
    .cfg     (cfg),
    .evn     (evn),
    .trg_hit (trg_hit),
    .tbl_we  (tbl_we),
    .tbl_adr (tbl_adr),
    .tbl_dat (tbl_dat),
    .raw_vld (raw_vld),
    .raw_dat (raw_dat),
    .raw_rdy (raw_rdy),
    .sts     (sts),
    .tro     (tro)
  );

  lg_out u_out (
    .bus     (bus),
    .rst_n   (rst_n),
    .cfg     (cfg),
    .raw_vld (raw_vld),
    .raw_dat (raw_dat),
    .raw_rdy (raw_rdy),
    .out_vld (out_vld),
    .out_dat (out_dat),
    .out_oe  (out_oe),
    .out_rdy (out_rdy)
  );

endmodule

// ==== verification/lg_chk.sv ====
/*
  Stream checker of the pattern generator testbench.
  Compares every output transfer with the reference sample and counts
  transfers, mismatches and interrupt pulses. The model configuration is
  written by the testbench before each run.
*/
`timescale 1ns/1ps

module lg_chk
  import lg_cfg_pkg::*;
(
  input logic bus,
  input logic rst_n,
  input logic out_vld,
  input dat_t out_dat,
  input dat_t out_oe,
  input logic out_rdy,
  input logic irq
);

  //////////////////////////////////////////////////
  // model state loaded between runs
  //////////////////////////////////////////////////

  dat_t tbl_copy [256];  // mirror of the waveform table
  ptr_t siz;
  ptr_t off;
  ptr_t ste;
  dat_t oen;
  dat_t msk;
  dat_t val;
  dat_t pol;
  int   bdl;             // samples per period or 0 when continuous
  int   k0;              // transfer count at run start

  int   xfer_cnt;        // all transfers since reset
  int   err_cnt;
  int   irq_cnt;
  dat_t exp_d;
  int   bad;

  // expected sample k of a run
  function automatic dat_t ref_sample(int k);
    longint   p;
    int       n;
    tbl_adr_t idx;
    dat_t     raw;
    dat_t     res;
    n   = (bdl > 0) ? k % bdl : k;  // each period restarts at the offset
    p   = (longint'(off) + longint'(n) * longint'(ste)) % longint'(siz);
    idx = tbl_adr_t'(p >> ptr_fw);  // integer part picks the entry
    raw = tbl_copy[idx];
    for (int b = 0; b < dat_w; b++) begin
      res[b] = (msk[b] ? raw[b] : val[b]) ^ pol[b];  // mask picks the table bit
    end
    return res;
  endfunction

  //////////////////////////////////////////////////
  // compare on every valid/ready edge
  //////////////////////////////////////////////////

  always @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      xfer_cnt <= 0;
      err_cnt  <= 0;
      irq_cnt  <= 0;
    end else begin
      bad = 0;
      if (irq) begin
        irq_cnt <= irq_cnt + 1;  // one cycle pulse
      end
      if (!out_vld && out_oe !== '0) begin
        $display("mismatch at %0t: output enable %h with no sample held, expected 00",
                 $time, out_oe);
        bad++;
      end
      if (out_vld && out_rdy) begin
        exp_d = ref_sample(xfer_cnt - k0);
        if (out_dat !== exp_d) begin
          $display("mismatch at %0t: sample %0d data %h, expected %h",
                   $time, xfer_cnt - k0, out_dat, exp_d);
          bad++;
        end
        if (out_oe !== oen) begin
          $display("mismatch at %0t: sample %0d output enable %h, expected %h",
                   $time, xfer_cnt - k0, out_oe, oen);
          bad++;
        end
        xfer_cnt <= xfer_cnt + 1;
      end
      err_cnt <= err_cnt + bad;
    end
  end

endmodule

// ==== verification/lg_tb.sv ====
/*
  Testbench of the logic pattern generator.
  Programs the DUT over the strobe bus, runs readback, continuous, burst,
  trigger and stop scenarios under random back-pressure, prints the verdict.
*/
`timescale 1ns/1ps
`include "lg_regmap.svh"

module lg_tb
  import lg_cfg_pkg::*;
();

  logic     bus;
  logic     rst_n;
  logic     reg_wen;
  logic     reg_ren;
  reg_adr_t reg_addr;
  reg_dat_t reg_wdata;
  reg_dat_t reg_rdata;
  logic     reg_ack;
  trg_t     ext_trg;
  logic     out_vld;
  dat_t     out_dat;
  dat_t     out_oe;
  logic     out_rdy;
  logic     irq;

  integer   seed = 32'h6279_0868;  // fixed seed for out_rdy
  logic     rdy_rand;              // random stalls on
  int       tb_err;                // bus, timeout and status errors
  int       err_mark;
  int       n_tests;
  int       n_fail;
  int       irq_mark;

  lg_top UUT (
    .bus       (bus),
    .rst_n     (rst_n),
    .reg_wen   (reg_wen),
    .reg_ren   (reg_ren),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .reg_ack   (reg_ack),
    .ext_trg   (ext_trg),
    .out_vld   (out_vld),
    .out_dat   (out_dat),
    .out_oe    (out_oe),
    .out_rdy   (out_rdy),
    .irq       (irq)
  );

  lg_chk u_chk (
    .bus     (bus),
    .rst_n   (rst_n),
    .out_vld (out_vld),
    .out_dat (out_dat),
    .out_oe  (out_oe),
    .out_rdy (out_rdy),
    .irq     (irq)
  );

  // 20 ns clock
  always begin
    bus = 1'b0;
    #10;
    bus = 1'b1;
    #10;
  end

  // sink back-pressure, ready about 3 cycles in 4
  always @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      out_rdy <= 1'b0;
    end else begin
      out_rdy <= rdy_rand ? (($random(seed) & 3) != 0) : 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // bus tasks
  //////////////////////////////////////////////////

  task automatic bus_write(input int adr, input int dat);
    int n;
    @(posedge bus);
    reg_wen   <= 1'b1;
    reg_addr  <= reg_adr_t'(adr);
    reg_wdata <= reg_dat_t'(dat);
    @(posedge bus);
    reg_wen <= 1'b0;
    n = 0;
    while (!reg_ack && n < 16) begin
      @(posedge bus);
      n++;
    end
    if (!reg_ack) begin
      $display("write to address %h was never acknowledged", adr);
      tb_err++;
    end
  endtask

  task automatic check_read(input int adr, input int exp);
    int n;
    @(posedge bus);
    reg_ren  <= 1'b1;
    reg_addr <= reg_adr_t'(adr);
    @(posedge bus);
    reg_ren <= 1'b0;
    n = 0;
    while (!reg_ack && n < 16) begin
      @(posedge bus);
      n++;
    end
    if (!reg_ack) begin
      $display("read of address %h was never acknowledged", adr);
      tb_err++;
    end else if (reg_rdata !== reg_dat_t'(exp)) begin
      $display("mismatch at %0t: address %h read %h, expected %h",
               $time, adr, reg_rdata, exp);
      tb_err++;
    end
  endtask

  task automatic write_check(input int adr, input int dat);
    bus_write(adr, dat);
    check_read(adr, dat);
  endtask

  //////////////////////////////////////////////////
  // setup and waits
  //////////////////////////////////////////////////

  task automatic fill_table();
    dat_t v;
    for (int i = 0; i < 256; i++) begin
      v = dat_t'((i * 37) ^ (i >> 5) ^ 'ha5);  // distinct per entry
      bus_write(`LG_TBL_BASE + i * `LG_TBL_STEP, int'(v));
      u_chk.tbl_copy[i] = v;
    end
  endtask

  // pointer and output settings, DUT and model alike
  task automatic program_cfg(input int siz, input int off, input int ste,
                             input int oen, input int msk, input int val, input int pol);
    bus_write(`LG_REG_SIZ, siz);
    bus_write(`LG_REG_OFF, off);
    bus_write(`LG_REG_STE, ste);
    bus_write(`LG_REG_OEN, oen);
    bus_write(`LG_REG_MSK, msk);
    bus_write(`LG_REG_VAL, val);
    bus_write(`LG_REG_POL, pol);
    u_chk.siz = ptr_t'(siz);
    u_chk.off = ptr_t'(off);
    u_chk.ste = ptr_t'(ste);
    u_chk.oen = dat_t'(oen);
    u_chk.msk = dat_t'(msk);
    u_chk.val = dat_t'(val);
    u_chk.pol = dat_t'(pol);
  endtask

  task automatic burst_cfg(input int ben, input int bdl, input int bpl, input int bpn);
    bus_write(`LG_REG_BDL, bdl);
    bus_write(`LG_REG_BPL, bpl);
    bus_write(`LG_REG_BPN, bpn);
    bus_write(`LG_REG_MOD, ben);  // finite, inf clear
    u_chk.bdl = (ben != 0) ? bdl : 0;
  endtask

  task automatic start_run();
    u_chk.k0 = u_chk.xfer_cnt;  // sample index restarts
    bus_write(`LG_REG_CTL, 'h1);  // armed
    bus_write(`LG_REG_CTL, 'h4);  // software trigger
  endtask

  task automatic wait_xfers(input int n, input int limit);
    int c;
    c = 0;
    while (u_chk.xfer_cnt - u_chk.k0 < n && c < limit) begin
      @(posedge bus);
      c++;
    end
    if (u_chk.xfer_cnt - u_chk.k0 < n) begin
      $display("timed out after %0d cycles waiting for %0d transfers", limit, n);
      tb_err++;
    end
  endtask

  task automatic wait_idle(input int limit);
    int c;
    c = 0;
    while (out_vld && c < limit) begin
      @(posedge bus);
      c++;
    end
    if (out_vld) begin
      $display("output still valid %0d cycles after the end of the run", limit);
      tb_err++;
    end
  endtask

  task automatic wait_valid(input int limit);
    int c;
    c = 0;
    while (!out_vld && c < limit) begin
      @(posedge bus);
      c++;
    end
    if (!out_vld) begin
      $display("enabled trigger did not start the sequencer");
      tb_err++;
    end
  endtask

  task automatic wait_irq(input int limit);
    int c;
    c = 0;
    while (u_chk.irq_cnt == irq_mark && c < limit) begin
      @(posedge bus);
      c++;
    end
    if (u_chk.irq_cnt == irq_mark) begin
      $display("no interrupt within %0d cycles of the burst start", limit);
      tb_err++;
    end
  endtask

  // no sample may appear for a while
  task automatic quiet(input int cycles);
    int hits;
    hits = 0;
    for (int c = 0; c < cycles; c++) begin
      @(posedge bus);
      if (out_vld) begin
        hits++;
      end
    end
    if (hits != 0) begin
      $display("output valid for %0d cycles while the sequencer should be idle", hits);
      tb_err++;
    end
  endtask

  task automatic stop_run();
    bus_write(`LG_REG_CTL, 'h2);
    wait_idle(64);
  endtask

  task automatic drive_trg(input int v, input int cycles);
    @(posedge bus);
    ext_trg <= trg_t'(v);
    repeat (cycles) @(posedge bus);
    ext_trg <= '0;
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = tb_err + u_chk.err_cnt;
    n_tests++;
    if (errs != err_mark) begin
      n_fail++;
    end
    $display("test %0d %s: %s, %0d transfers", n_tests, name,
             (errs == err_mark) ? "ok" : "failed", u_chk.xfer_cnt - u_chk.k0);
    err_mark = errs;
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    rst_n     <= 1'b0;
    reg_wen   <= 1'b0;
    reg_ren   <= 1'b0;
    reg_addr  <= '0;
    reg_wdata <= '0;
    ext_trg   <= '0;
    rdy_rand  <= 1'b0;
    repeat (4) @(posedge bus);
    rst_n <= 1'b1;

    // status after reset, then every config register
    check_read(`LG_REG_CTL, 0);
    check_read(`LG_REG_SBL, 0);
    check_read(`LG_REG_SBN, 0);
    write_check(`LG_REG_TRG, 'ha);
    write_check(`LG_REG_MOD, 'h3);
    write_check(`LG_REG_SIZ, 'hc800);
    write_check(`LG_REG_OFF, 'h1040);
    write_check(`LG_REG_STE, 'h01a0);
    write_check(`LG_REG_BDL, 'h105);  // nine bits
    write_check(`LG_REG_BPL, 'h1234);
    write_check(`LG_REG_BPN, 'h0abc);
    write_check(`LG_REG_OEN, 'h5a);
    write_check(`LG_REG_MSK, 'h3c);
    write_check(`LG_REG_VAL, 'ha5);
    write_check(`LG_REG_POL, 'h81);
    bus_write(`LG_REG_MOD, 0);
    bus_write(`LG_REG_TRG, 0);
    end_test("register readback");

    // 200 entries, step 1.625, wraps several times
    fill_table();
    program_cfg('hc800, 'h1040, 'h01a0, 'hff, 'hff, 'h00, 'h00);
    rdy_rand <= 1'b1;
    start_run();
    wait_xfers(600, 6000);
    stop_run();
    end_test("continuous fractional step");

    program_cfg('hf000, 'h0080, 'h0b40, 'h5a, 'h3c, 'ha5, 'h81);
    start_run();
    wait_xfers(200, 2000);
    stop_run();
    end_test("output combining");

    // 3 periods of 5 samples in 12 steps
    program_cfg('h4000, 'h0300, 'h0280, 'hff, 'hff, 'h00, 'h00);
    burst_cfg(1, 5, 12, 3);
    irq_mark = u_chk.irq_cnt;
    start_run();
    wait_irq(3000);
    wait_idle(64);
    quiet(50);
    if (u_chk.xfer_cnt - u_chk.k0 != 15) begin
      $display("mismatch at %0t: burst moved %0d samples, expected 15",
               $time, u_chk.xfer_cnt - u_chk.k0);
      tb_err++;
    end
    if (u_chk.irq_cnt - irq_mark != 1) begin
      $display("mismatch at %0t: %0d interrupt pulses, expected 1",
               $time, u_chk.irq_cnt - irq_mark);
      tb_err++;
    end
    check_read(`LG_REG_CTL, 0);  // back in idle
    burst_cfg(0, 0, 0, 0);
    end_test("finite burst");

    // only line 1 may start the run
    bus_write(`LG_REG_TRG, 'h2);
    u_chk.k0 = u_chk.xfer_cnt;
    bus_write(`LG_REG_CTL, 'h1);
    drive_trg('h1, 4);
    quiet(40);
    check_read(`LG_REG_CTL, 1);  // still armed
    drive_trg('h2, 1);
    wait_valid(20);
    wait_xfers(30, 400);
    stop_run();
    bus_write(`LG_REG_TRG, 0);
    end_test("external triggers");

    start_run();
    wait_xfers(50, 600);
    bus_write(`LG_REG_CTL, 'h2);
    wait_idle(32);
    quiet(20);
    check_read(`LG_REG_CTL, 0);  // run flag clear
    end_test("stop");

    $display("tests %0d, failed %0d, transfers %0d, errors %0d",
             n_tests, n_fail, u_chk.xfer_cnt, tb_err + u_chk.err_cnt);
    if (tb_err + u_chk.err_cnt == 0 && n_fail == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+include
rtl/lg_cfg_pkg.sv
rtl/lg_evn_pkg.sv
rtl/lg_regs.sv
rtl/lg_seq.sv
rtl/lg_out.sv
rtl/lg_top.sv
verification/lg_chk.sv
verification/lg_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the pattern generator testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -j 0 -f src.f --top-module lg_tb -o lg_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/lg_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "Result: PASSED" "$LOG"; then
  echo "no verdict found in $LOG"
  exit 1
fi
exit 0
